/* sim.f */
+incdir+bench
src/rv_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_int_pipe.sv
bench/tb_rv_int_pipe.sv

/* bench/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural state, x0 is never written
logic [31:0] model_regs [0:31];

function automatic void clear_model();
  for (int k = 0; k < 32; k++) begin
    model_regs[k] = '0;
  end
endfunction

// immediates straight from the bit positions of the isa formats
function automatic logic [31:0] i_imm(input logic [31:0] w);
  return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [31:0] b_imm(input logic [31:0] w);
  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] u_imm(input logic [31:0] w);
  return {w[31:12], 12'b0};
endfunction

function automatic logic [31:0] j_imm(input logic [31:0] w);
  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
endfunction

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// one instruction in issue order, fields not produced stay zero
function automatic void model_step(input logic [31:0] w, input logic [31:0] pc,
                                   output logic [4:0] rd, output logic [31:0] data,
                                   output logic taken, output logic [31:0] target,
                                   output logic illegal);
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  f3 = w[14:12];
  f7 = w[31:25];
  a = model_regs[w[19:15]];
  b = model_regs[w[24:20]];
  rd = '0;
  data = '0;
  taken = 1'b0;
  target = '0;
  illegal = 1'b0;
  case (w[6:0])
    OPC_LUI: begin
      rd = w[11:7];
      data = u_imm(w);
    end
    OPC_AUIPC: begin
      rd = w[11:7];
      data = pc + u_imm(w);
    end
    OPC_JAL: begin
      rd = w[11:7];
      data = pc + 32'd4;
      taken = 1'b1;
      target = pc + j_imm(w);
    end
    OPC_JALR: begin
      if (f3 == 3'd0) begin
        rd = w[11:7];
        data = pc + 32'd4;
        taken = 1'b1;
        target = (a + i_imm(w)) & ~32'd1;
      end else begin
        illegal = 1'b1;
      end
    end
    OPC_BRANCH: begin
      if (f3 == 3'd2 || f3 == 3'd3) begin
        illegal = 1'b1;
      end else begin
        taken = branch_taken(f3, a, b);
        target = pc + b_imm(w);
      end
    end
    OPC_OPIMM: begin
      if ((f3 == 3'd1 && f7 != 7'h00) ||
          (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
        illegal = 1'b1;
      end else begin
        rd = w[11:7];
        data = alu_result(f3, f3 == 3'd5 && f7 == 7'h20, a, i_imm(w));
      end
    end
    OPC_OP: begin
      if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        rd = w[11:7];
        data = alu_result(f3, f7 == 7'h20, a, b);
      end else begin
        illegal = 1'b1;
      end
    end
    default: illegal = 1'b1;
  endcase
  if (!illegal && rd != 5'd0) begin
    model_regs[rd] = data;
  end
endfunction

`endif

/* bench/tb_rv_int_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_int_pipe;
  import rv_pkg::*;

  localparam int N_INST     = 2000;
  localparam int MAX_CYCLES = 4 * N_INST + 100;

  typedef struct packed {
    logic [31:0] due;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        taken;
    logic [31:0] target;
    logic        illegal;
  } expect_t;

  logic        clk;
  logic        rst_i;
  logic        inst_valid_i;
  rv_inst_t    inst_i;
  logic [31:0] pc_i;
  logic        res_valid_o;
  logic [31:0] res_pc_o;
  logic [4:0]  res_rd_o;
  logic [31:0] res_data_o;
  logic        res_taken_o;
  logic [31:0] res_target_o;
  logic        res_illegal_o;

  logic [31:0] rng_state;
  logic [31:0] cycle;
  logic [31:0] run_cycles;
  logic [31:0] next_pc;
  rv_inst_t    word;
  logic [4:0]  m_rd;
  logic [31:0] m_data;
  logic        m_taken;
  logic [31:0] m_target;
  logic        m_illegal;
  expect_t     entry;
  expect_t     head;
  logic        due_now;
  expect_t     exp_q [$];

  `include "rv_ref_model.svh"

  rv_int_pipe dut0 (
    .clk(clk), .rst_i(rst_i),
    .inst_valid_i(inst_valid_i), .inst_i(inst_i), .pc_i(pc_i),
    .res_valid_o(res_valid_o), .res_pc_o(res_pc_o), .res_rd_o(res_rd_o),
    .res_data_o(res_data_o), .res_taken_o(res_taken_o),
    .res_target_o(res_target_o), .res_illegal_o(res_illegal_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic fail_run();
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  // lcg with a xor-shift on the way out to hide the weak low bits
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ (rng_state >> 15);
  endfunction

  function automatic rv_inst_t make_word();
    rv_inst_t    w;
    logic [31:0] r;
    logic [2:0]  f3;
    r = next_rand();
    w = next_rand();
    f3 = r[15:13];
    // one in sixteen stays fully random
    if (r[3:0] == 4'd0) begin
      return w;
    end
    w.r.rd  = {2'b00, r[6:4]};
    w.r.rs1 = {2'b00, r[9:7]};
    w.r.rs2 = {2'b00, r[12:10]};
    if (r[19:16] < 4'd5) begin
      w.r.opcode = OPC_OP;
      w.r.funct3 = f3;
      w.r.funct7 = (r[20] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    end else if (r[19:16] < 4'd10) begin
      w.i.opcode = OPC_OPIMM;
      w.i.funct3 = f3;
      if (f3 == 3'd1) begin
        w.r.funct7 = 7'h00;
      end else if (f3 == 3'd5) begin
        w.r.funct7 = r[20] ? 7'h20 : 7'h00;
      end
    end else if (r[19:16] == 4'd10) begin
      w.u.opcode = OPC_LUI;
    end else if (r[19:16] == 4'd11) begin
      w.u.opcode = OPC_AUIPC;
    end else if (r[19:16] == 4'd12) begin
      w.j.opcode = OPC_JAL;
    end else if (r[19:16] == 4'd13) begin
      w.i.opcode = OPC_JALR;
      w.i.funct3 = 3'd0;
    end else begin
      // funct3 2 and 3 fold onto beq and bne
      w.b.opcode = OPC_BRANCH;
      w.b.funct3 = (f3 == 3'd2 || f3 == 3'd3) ? (f3 ^ 3'b010) : f3;
    end
    return w;
  endfunction

  // results are stable between edges, so compare on the falling edge
  always @(negedge clk) begin
    if (!rst_i) begin
      due_now = (exp_q.size() > 0) && (exp_q[0].due == cycle);
      check_value("res_valid_o", res_valid_o, due_now);
      if (due_now) begin
        head = exp_q.pop_front();
        check_value("res_pc_o", res_pc_o, head.pc);
        check_value("res_rd_o", res_rd_o, head.rd);
        check_value("res_data_o", res_data_o, head.data);
        check_value("res_taken_o", res_taken_o, head.taken);
        check_value("res_target_o", res_target_o, head.target);
        check_value("res_illegal_o", res_illegal_o, head.illegal);
      end
    end
  end

  always @(posedge clk) begin
    if (rst_i) begin
      run_cycles <= '0;
    end else begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= MAX_CYCLES) begin
        $display("timeout: results did not drain within %0d cycles", MAX_CYCLES);
        fail_run();
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    inst_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    cycle = '0;
    run_cycles = '0;
    rng_state = 32'h88bd_3fdb;
    next_pc = 32'h0000_1000;
    clear_model();
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    // idle stretch, res_valid_o has to stay low
    repeat (6) @(posedge clk);
    for (int n = 0; n < N_INST; n++) begin
      if (next_rand() % 4 == 0) begin
        @(posedge clk);
        inst_valid_i <= 1'b0;
        inst_i <= next_rand();
      end
      @(posedge clk);
      word = make_word();
      model_step(word, next_pc, m_rd, m_data, m_taken, m_target, m_illegal);
      // sampled on the next edge, retired one edge later
      entry.due = cycle + 3;
      entry.pc = next_pc;
      entry.rd = m_rd;
      entry.data = m_data;
      entry.taken = m_taken;
      entry.target = m_target;
      entry.illegal = m_illegal;
      exp_q.push_back(entry);
      inst_valid_i <= 1'b1;
      inst_i <= word;
      pc_i <= next_pc;
      next_pc = next_pc + 32'd4;
    end
    @(posedge clk);
    inst_valid_i <= 1'b0;
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("%0d results never appeared on the result port", exp_q.size());
      fail_run();
    end
  end

endmodule

`default_nettype wire

/* src/rv_int_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_int_pipe (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      inst_valid_i,
  input  rv_pkg::rv_inst_t          inst_i,
  input  logic [rv_pkg::XLEN-1:0]   pc_i,
  output logic                      res_valid_o,
  output logic [rv_pkg::XLEN-1:0]   res_pc_o,
  output logic [rv_pkg::REG_AW-1:0] res_rd_o,
  output logic [rv_pkg::XLEN-1:0]   res_data_o,
  output logic                      res_taken_o,
  output logic [rv_pkg::XLEN-1:0]   res_target_o,
  output logic                      res_illegal_o
);
  import rv_pkg::*;

  logic [REG_AW-1:0]   rs1_idx, rs2_idx;
  logic [XLEN-1:0]     rs1_data, rs2_data;
  logic                dec_valid, dec_illegal;
  logic [XLEN-1:0]     dec_pc, dec_op1, dec_op2, dec_imm;
  logic [CLS_W-1:0]    dec_cls;
  logic [ALU_OP_W-1:0] dec_alu_op;
  logic [REG_AW-1:0]   dec_rd;
  logic                ex_valid, ex_taken, ex_illegal;
  logic [XLEN-1:0]     ex_pc, ex_data, ex_target;
  logic [REG_AW-1:0]   ex_rd;

  rv_decode u_decode (
    .clk(clk), .rst_i(rst_i),
    .inst_valid_i(inst_valid_i), .inst_i(inst_i), .pc_i(pc_i),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex_rd_i(ex_rd), .ex_data_i(ex_data),
    .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx),
    .dec_valid_o(dec_valid), .dec_pc_o(dec_pc), .dec_cls_o(dec_cls),
    .dec_alu_op_o(dec_alu_op), .dec_rd_o(dec_rd),
    .dec_op1_o(dec_op1), .dec_op2_o(dec_op2), .dec_imm_o(dec_imm),
    .dec_illegal_o(dec_illegal)
  );

  rv_execute u_execute (
    .dec_valid_i(dec_valid), .dec_pc_i(dec_pc), .dec_cls_i(dec_cls),
    .dec_alu_op_i(dec_alu_op), .dec_rd_i(dec_rd),
    .dec_op1_i(dec_op1), .dec_op2_i(dec_op2), .dec_imm_i(dec_imm),
    .dec_illegal_i(dec_illegal),
    .ex_valid_o(ex_valid), .ex_pc_o(ex_pc), .ex_rd_o(ex_rd), .ex_data_o(ex_data),
    .ex_taken_o(ex_taken), .ex_target_o(ex_target), .ex_illegal_o(ex_illegal)
  );

  rv_result u_result (
    .clk(clk), .rst_i(rst_i),
    .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
    .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_rd_i(ex_rd), .ex_data_i(ex_data),
    .ex_taken_i(ex_taken), .ex_target_i(ex_target), .ex_illegal_i(ex_illegal),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .res_valid_o(res_valid_o), .res_pc_o(res_pc_o), .res_rd_o(res_rd_o),
    .res_data_o(res_data_o), .res_taken_o(res_taken_o),
    .res_target_o(res_target_o), .res_illegal_o(res_illegal_o)
  );

endmodule

`default_nettype wire

/* src/rv_result.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_result (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [rv_pkg::REG_AW-1:0] rs1_idx_i,
  input  logic [rv_pkg::REG_AW-1:0] rs2_idx_i,
  input  logic                      ex_valid_i,
  input  logic [rv_pkg::XLEN-1:0]   ex_pc_i,
  input  logic [rv_pkg::REG_AW-1:0] ex_rd_i,
  input  logic [rv_pkg::XLEN-1:0]   ex_data_i,
  input  logic                      ex_taken_i,
  input  logic [rv_pkg::XLEN-1:0]   ex_target_i,
  input  logic                      ex_illegal_i,
  output logic [rv_pkg::XLEN-1:0]   rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]   rs2_data_o,
  output logic                      res_valid_o,
  output logic [rv_pkg::XLEN-1:0]   res_pc_o,
  output logic [rv_pkg::REG_AW-1:0] res_rd_o,
  output logic [rv_pkg::XLEN-1:0]   res_data_o,
  output logic                      res_taken_o,
  output logic [rv_pkg::XLEN-1:0]   res_target_o,
  output logic                      res_illegal_o
);
  import rv_pkg::*;

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs [1:2**REG_AW-1];

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 1; k < 2**REG_AW; k++) begin
        regs[k] <= '0;
      end
    end else if (ex_valid_i && ex_rd_i != '0) begin
      regs[ex_rd_i] <= ex_data_i;
    end
  end

  // result port, same edge as the write
  always_ff @(posedge clk) begin
    if (rst_i) begin
      res_valid_o   <= 1'b0;
      res_pc_o      <= '0;
      res_rd_o      <= '0;
      res_data_o    <= '0;
      res_taken_o   <= 1'b0;
      res_target_o  <= '0;
      res_illegal_o <= 1'b0;
    end else begin
      res_valid_o <= ex_valid_i;
      if (ex_valid_i) begin
        res_pc_o      <= ex_pc_i;
        res_rd_o      <= ex_rd_i;
        res_data_o    <= ex_data_i;
        res_taken_o   <= ex_taken_i;
        res_target_o  <= ex_target_i;
        res_illegal_o <= ex_illegal_i;
      end
    end
  end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  logic                        dec_valid_i,
  input  logic [rv_pkg::XLEN-1:0]     dec_pc_i,
  input  logic [rv_pkg::CLS_W-1:0]    dec_cls_i,
  input  logic [rv_pkg::ALU_OP_W-1:0] dec_alu_op_i,
  input  logic [rv_pkg::REG_AW-1:0]   dec_rd_i,
  input  logic [rv_pkg::XLEN-1:0]     dec_op1_i,
  input  logic [rv_pkg::XLEN-1:0]     dec_op2_i,
  input  logic [rv_pkg::XLEN-1:0]     dec_imm_i,
  input  logic                        dec_illegal_i,
  output logic                        ex_valid_o,
  output logic [rv_pkg::XLEN-1:0]     ex_pc_o,
  output logic [rv_pkg::REG_AW-1:0]   ex_rd_o,
  output logic [rv_pkg::XLEN-1:0]     ex_data_o,
  output logic                        ex_taken_o,
  output logic [rv_pkg::XLEN-1:0]     ex_target_o,
  output logic                        ex_illegal_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] op_a, op_b, alu_res, pc_rel;
  logic            cmp, is_jump;

  // operand select by class
  always_comb begin
    case (dec_cls_i)
      CLS_LUI:   op_a = '0;
      CLS_AUIPC: op_a = dec_pc_i;
      default:   op_a = dec_op1_i;
    endcase
    if (dec_cls_i == CLS_OPREG || dec_cls_i == CLS_BRANCH) begin
      op_b = dec_op2_i;
    end else begin
      op_b = dec_imm_i;
    end
  end

  always_comb begin
    alu_res = '0;
    cmp     = 1'b0;
    case (dec_alu_op_i)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_BEQ:  cmp = (op_a == op_b);
      ALU_BNE:  cmp = (op_a != op_b);
      ALU_BLT:  cmp = ($signed(op_a) < $signed(op_b));
      ALU_BGE:  cmp = ($signed(op_a) >= $signed(op_b));
      ALU_BLTU: cmp = (op_a < op_b);
      ALU_BGEU: cmp = (op_a >= op_b);
      default:  alu_res = '0;
    endcase
  end

  assign is_jump = (dec_cls_i == CLS_JAL) || (dec_cls_i == CLS_JALR);
  assign pc_rel  = dec_pc_i + dec_imm_i;

  // jalr sums op1 and imm through the alu add
  always_comb begin
    case (dec_cls_i)
      CLS_JAL, CLS_BRANCH: ex_target_o = pc_rel;
      CLS_JALR:            ex_target_o = {alu_res[XLEN-1:1], 1'b0};
      default:             ex_target_o = '0;
    endcase
  end

  assign ex_taken_o   = is_jump | ((dec_cls_i == CLS_BRANCH) & cmp);
  assign ex_data_o    = is_jump ? dec_pc_i + 32'd4 : alu_res;
  assign ex_valid_o   = dec_valid_i;
  assign ex_pc_o      = dec_pc_i;
  assign ex_rd_o      = dec_valid_i ? dec_rd_i : '0;
  assign ex_illegal_o = dec_illegal_i;

endmodule

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            inst_valid_i,
  input  rv_pkg::rv_inst_t                inst_i,
  input  logic [rv_pkg::XLEN-1:0]         pc_i,
  input  logic [rv_pkg::XLEN-1:0]         rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]         rs2_data_i,
  input  logic [rv_pkg::REG_AW-1:0]       ex_rd_i,
  input  logic [rv_pkg::XLEN-1:0]         ex_data_i,
  output logic [rv_pkg::REG_AW-1:0]       rs1_idx_o,
  output logic [rv_pkg::REG_AW-1:0]       rs2_idx_o,
  output logic                            dec_valid_o,
  output logic [rv_pkg::XLEN-1:0]         dec_pc_o,
  output logic [rv_pkg::CLS_W-1:0]        dec_cls_o,
  output logic [rv_pkg::ALU_OP_W-1:0]     dec_alu_op_o,
  output logic [rv_pkg::REG_AW-1:0]       dec_rd_o,
  output logic [rv_pkg::XLEN-1:0]         dec_op1_o,
  output logic [rv_pkg::XLEN-1:0]         dec_op2_o,
  output logic [rv_pkg::XLEN-1:0]         dec_imm_o,
  output logic                            dec_illegal_o
);
  import rv_pkg::*;

  function automatic logic match(input logic [31:0] word, input logic [31:0] mask,
                                 input logic [31:0] value);
    return (word & mask) == value;
  endfunction

  logic is_lui, is_auipc, is_jal, is_jalr;
  logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
  logic is_addi, is_slti, is_sltiu, is_xori, is_ori, is_andi;
  logic is_slli, is_srli, is_srai;
  logic is_add, is_sub, is_sll, is_slt, is_sltu, is_xor, is_srl, is_sra, is_or, is_and;
  logic t_branch, t_opimm, t_opreg;
  logic r_fmt, i_fmt, b_fmt, u_fmt, j_fmt, illegal;
  logic [REG_AW-1:0] rs1_idx, rs2_idx, rd_idx;
  logic [XLEN-1:0] imm_i, imm_b, imm_u, imm_j, imm;
  logic [ALU_OP_W-1:0] alu_op;
  logic [CLS_W-1:0] cls;
  logic [XLEN-1:0] op1, op2;

  assign is_lui   = match(inst_i, MASK_OPCODE, LUI_VAL);
  assign is_auipc = match(inst_i, MASK_OPCODE, AUIPC_VAL);
  assign is_jal   = match(inst_i, MASK_OPCODE, JAL_VAL);
  assign is_jalr  = match(inst_i, MASK_FUNC3, JALR_VAL);
  assign is_beq   = match(inst_i, MASK_FUNC3, BEQ_VAL);
  assign is_bne   = match(inst_i, MASK_FUNC3, BNE_VAL);
  assign is_blt   = match(inst_i, MASK_FUNC3, BLT_VAL);
  assign is_bge   = match(inst_i, MASK_FUNC3, BGE_VAL);
  assign is_bltu  = match(inst_i, MASK_FUNC3, BLTU_VAL);
  assign is_bgeu  = match(inst_i, MASK_FUNC3, BGEU_VAL);
  assign is_addi  = match(inst_i, MASK_FUNC3, ADDI_VAL);
  assign is_slti  = match(inst_i, MASK_FUNC3, SLTI_VAL);
  assign is_sltiu = match(inst_i, MASK_FUNC3, SLTIU_VAL);
  assign is_xori  = match(inst_i, MASK_FUNC3, XORI_VAL);
  assign is_ori   = match(inst_i, MASK_FUNC3, ORI_VAL);
  assign is_andi  = match(inst_i, MASK_FUNC3, ANDI_VAL);
  assign is_slli  = match(inst_i, MASK_FUNC7, SLLI_VAL);
  assign is_srli  = match(inst_i, MASK_FUNC7, SRLI_VAL);
  assign is_srai  = match(inst_i, MASK_FUNC7, SRAI_VAL);
  assign is_add   = match(inst_i, MASK_FUNC7, ADD_VAL);
  assign is_sub   = match(inst_i, MASK_FUNC7, SUB_VAL);
  assign is_sll   = match(inst_i, MASK_FUNC7, SLL_VAL);
  assign is_slt   = match(inst_i, MASK_FUNC7, SLT_VAL);
  assign is_sltu  = match(inst_i, MASK_FUNC7, SLTU_VAL);
  assign is_xor   = match(inst_i, MASK_FUNC7, XOR_VAL);
  assign is_srl   = match(inst_i, MASK_FUNC7, SRL_VAL);
  assign is_sra   = match(inst_i, MASK_FUNC7, SRA_VAL);
  assign is_or    = match(inst_i, MASK_FUNC7, OR_VAL);
  assign is_and   = match(inst_i, MASK_FUNC7, AND_VAL);

  assign t_branch = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
  assign t_opimm  = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi |
                    is_slli | is_srli | is_srai;
  assign t_opreg  = is_add | is_sub | is_sll | is_slt | is_sltu | is_xor |
                    is_srl | is_sra | is_or | is_and;

  // format groups
  assign r_fmt   = t_opreg;
  assign i_fmt   = t_opimm | is_jalr;
  assign b_fmt   = t_branch;
  assign u_fmt   = is_lui | is_auipc;
  assign j_fmt   = is_jal;
  assign illegal = ~(r_fmt | i_fmt | b_fmt | u_fmt | j_fmt);

  // unused index fields read as x0
  assign rs1_idx = (r_fmt | i_fmt | b_fmt) ? inst_i.r.rs1 : '0;
  assign rs2_idx = (r_fmt | b_fmt) ? inst_i.r.rs2 : '0;
  assign rd_idx  = (r_fmt | i_fmt | u_fmt | j_fmt) ? inst_i.r.rd : '0;

  assign imm_i = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
  assign imm_b = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                  inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
  assign imm_u = {inst_i.u.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                  inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
  assign imm   = ({XLEN{i_fmt}} & imm_i) | ({XLEN{b_fmt}} & imm_b) |
                 ({XLEN{u_fmt}} & imm_u) | ({XLEN{j_fmt}} & imm_j);

  // add is the zero code, so lui, auipc and the jumps fall through to it
  assign alu_op = ({ALU_OP_W{is_sub}}            & ALU_SUB)  |
                  ({ALU_OP_W{is_xor | is_xori}}   & ALU_XOR)  |
                  ({ALU_OP_W{is_or | is_ori}}     & ALU_OR)   |
                  ({ALU_OP_W{is_and | is_andi}}   & ALU_AND)  |
                  ({ALU_OP_W{is_sll | is_slli}}   & ALU_SLL)  |
                  ({ALU_OP_W{is_srl | is_srli}}   & ALU_SRL)  |
                  ({ALU_OP_W{is_sra | is_srai}}   & ALU_SRA)  |
                  ({ALU_OP_W{is_slt | is_slti}}   & ALU_SLT)  |
                  ({ALU_OP_W{is_sltu | is_sltiu}} & ALU_SLTU) |
                  ({ALU_OP_W{is_beq}}             & ALU_BEQ)  |
                  ({ALU_OP_W{is_bne}}             & ALU_BNE)  |
                  ({ALU_OP_W{is_blt}}             & ALU_BLT)  |
                  ({ALU_OP_W{is_bge}}             & ALU_BGE)  |
                  ({ALU_OP_W{is_bltu}}            & ALU_BLTU) |
                  ({ALU_OP_W{is_bgeu}}            & ALU_BGEU);

  assign cls = ({CLS_W{is_lui}}   & CLS_LUI)    |
               ({CLS_W{is_auipc}} & CLS_AUIPC)  |
               ({CLS_W{is_jal}}   & CLS_JAL)    |
               ({CLS_W{is_jalr}}  & CLS_JALR)   |
               ({CLS_W{t_branch}} & CLS_BRANCH) |
               ({CLS_W{t_opimm}}  & CLS_OPIMM)  |
               ({CLS_W{t_opreg}}  & CLS_OPREG);

  // execute bypass, never for x0
  assign rs1_idx_o = rs1_idx;
  assign rs2_idx_o = rs2_idx;
  assign op1 = (rs1_idx != '0 && rs1_idx == ex_rd_i) ? ex_data_i : rs1_data_i;
  assign op2 = (rs2_idx != '0 && rs2_idx == ex_rd_i) ? ex_data_i : rs2_data_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i) begin
      dec_pc_o      <= pc_i;
      dec_cls_o     <= cls;
      dec_alu_op_o  <= alu_op;
      dec_rd_o      <= rd_idx;
      dec_op1_o     <= op1;
      dec_op2_o     <= op2;
      dec_imm_o     <= imm;
      dec_illegal_o <= illegal;
    end
  end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // match masks
  localparam logic [31:0] MASK_OPCODE = 32'h0000_007f;
  localparam logic [31:0] MASK_FUNC3  = 32'h0000_707f;
  localparam logic [31:0] MASK_FUNC7  = 32'hfe00_707f;

  // patterns, laid out as funct7 / rs2+rs1 / funct3 / rd / opcode
  localparam logic [31:0] LUI_VAL   = {25'b0, OPC_LUI};
  localparam logic [31:0] AUIPC_VAL = {25'b0, OPC_AUIPC};
  localparam logic [31:0] JAL_VAL   = {25'b0, OPC_JAL};
  localparam logic [31:0] JALR_VAL  = {17'b0, 3'b000, 5'b0, OPC_JALR};

  localparam logic [31:0] BEQ_VAL  = {17'b0, 3'b000, 5'b0, OPC_BRANCH};
  localparam logic [31:0] BNE_VAL  = {17'b0, 3'b001, 5'b0, OPC_BRANCH};
  localparam logic [31:0] BLT_VAL  = {17'b0, 3'b100, 5'b0, OPC_BRANCH};
  localparam logic [31:0] BGE_VAL  = {17'b0, 3'b101, 5'b0, OPC_BRANCH};
  localparam logic [31:0] BLTU_VAL = {17'b0, 3'b110, 5'b0, OPC_BRANCH};
  localparam logic [31:0] BGEU_VAL = {17'b0, 3'b111, 5'b0, OPC_BRANCH};

  localparam logic [31:0] ADDI_VAL  = {17'b0, 3'b000, 5'b0, OPC_OPIMM};
  localparam logic [31:0] SLTI_VAL  = {17'b0, 3'b010, 5'b0, OPC_OPIMM};
  localparam logic [31:0] SLTIU_VAL = {17'b0, 3'b011, 5'b0, OPC_OPIMM};
  localparam logic [31:0] XORI_VAL  = {17'b0, 3'b100, 5'b0, OPC_OPIMM};
  localparam logic [31:0] ORI_VAL   = {17'b0, 3'b110, 5'b0, OPC_OPIMM};
  localparam logic [31:0] ANDI_VAL  = {17'b0, 3'b111, 5'b0, OPC_OPIMM};
  localparam logic [31:0] SLLI_VAL  = {7'b0000000, 10'b0, 3'b001, 5'b0, OPC_OPIMM};
  localparam logic [31:0] SRLI_VAL  = {7'b0000000, 10'b0, 3'b101, 5'b0, OPC_OPIMM};
  localparam logic [31:0] SRAI_VAL  = {7'b0100000, 10'b0, 3'b101, 5'b0, OPC_OPIMM};

  localparam logic [31:0] ADD_VAL  = {7'b0000000, 10'b0, 3'b000, 5'b0, OPC_OP};
  localparam logic [31:0] SUB_VAL  = {7'b0100000, 10'b0, 3'b000, 5'b0, OPC_OP};
  localparam logic [31:0] SLL_VAL  = {7'b0000000, 10'b0, 3'b001, 5'b0, OPC_OP};
  localparam logic [31:0] SLT_VAL  = {7'b0000000, 10'b0, 3'b010, 5'b0, OPC_OP};
  localparam logic [31:0] SLTU_VAL = {7'b0000000, 10'b0, 3'b011, 5'b0, OPC_OP};
  localparam logic [31:0] XOR_VAL  = {7'b0000000, 10'b0, 3'b100, 5'b0, OPC_OP};
  localparam logic [31:0] SRL_VAL  = {7'b0000000, 10'b0, 3'b101, 5'b0, OPC_OP};
  localparam logic [31:0] SRA_VAL  = {7'b0100000, 10'b0, 3'b101, 5'b0, OPC_OP};
  localparam logic [31:0] OR_VAL   = {7'b0000000, 10'b0, 3'b110, 5'b0, OPC_OP};
  localparam logic [31:0] AND_VAL  = {7'b0000000, 10'b0, 3'b111, 5'b0, OPC_OP};

  // alu operation codes
  localparam int ALU_OP_W = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_BEQ  = 4'd10;
  localparam logic [ALU_OP_W-1:0] ALU_BNE  = 4'd11;
  localparam logic [ALU_OP_W-1:0] ALU_BLT  = 4'd12;
  localparam logic [ALU_OP_W-1:0] ALU_BGE  = 4'd13;
  localparam logic [ALU_OP_W-1:0] ALU_BLTU = 4'd14;
  localparam logic [ALU_OP_W-1:0] ALU_BGEU = 4'd15;

  // instruction class, picks operands and result kind
  localparam int CLS_W = 3;
  localparam logic [CLS_W-1:0] CLS_NONE   = 3'd0;
  localparam logic [CLS_W-1:0] CLS_LUI    = 3'd1;
  localparam logic [CLS_W-1:0] CLS_AUIPC  = 3'd2;
  localparam logic [CLS_W-1:0] CLS_JAL    = 3'd3;
  localparam logic [CLS_W-1:0] CLS_JALR   = 3'd4;
  localparam logic [CLS_W-1:0] CLS_BRANCH = 3'd5;
  localparam logic [CLS_W-1:0] CLS_OPIMM  = 3'd6;
  localparam logic [CLS_W-1:0] CLS_OPREG  = 3'd7;

  // one word, six formats
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } rv_inst_t;

endpackage

`default_nettype wire
